/* include/mcu_macros.svh */
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// Value returned on the first data byte of IDENTIFY
`define MCU_FPGA_ID 8'h64

// Transfer buffer depth in 16-bit words
`define MCU_BUF_WORDS 512

// External byte address advance per word
`define MCU_MEM_STEP 32'd2

// Register offsets
`define MCU_REG_STATUS 8'd0
`define MCU_REG_MEM_ADDRESS 8'd1
`define MCU_REG_MEM_SCR 8'd2

`endif

/* list.f */
+incdir+include
src/mcu_proto_pkg.sv
src/mcu_mem_pkg.sv
src/mcu_ifaces.sv
src/mcu_protocol.sv
src/mcu_regs.sv
src/mcu_buffer.sv
src/mem_dma.sv
src/mcu_top.sv
sim/mcu_properties.sv
sim/mcu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mcu_tb --Mdir obj_dir -o mcu_sim -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mcu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
    exit 1
fi

exit 0

/* sim/mcu_properties.sv */
`timescale 1ns/100ps

module mcu_properties
    import mcu_mem_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      mem_request,
    input logic      mem_ack,
    input mem_addr_t mem_address,
    input word_t     mem_wdata,
    input logic      busy
);

    // A waiting request keeps its address and data
    property request_held;
        @(posedge clk) disable iff (reset)
        mem_request && !mem_ack |=> mem_request && $stable(mem_address) && $stable(mem_wdata);
    endproperty

    property request_drops;
        @(posedge clk) disable iff (reset)
        mem_request && mem_ack |=> !mem_request;
    endproperty

    property idle_after_reset;
        @(posedge clk) reset |=> !busy;
    endproperty

    assert property (request_held)
        else $error("memory request changed before it was acked");
    assert property (request_drops)
        else $error("memory request stayed high after ack");
    assert property (idle_after_reset)
        else $error("DMA busy high after reset");

endmodule

bind mem_dma mcu_properties props0 (
    .clk(clk),
    .reset(reset),
    .mem_request(mem_request),
    .mem_ack(mem_ack),
    .mem_address(mem_address),
    .mem_wdata(mem_wdata),
    .busy(ctrl.busy)
);

/* sim/mcu_tb.sv */
`timescale 1ns/100ps

module mcu_tb
    import mcu_proto_pkg::*;
    import mcu_mem_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    // Frames and DMA take about 1000 cycles in all
    localparam int WATCHDOG_NS = 200000;

    localparam byte_t OP_IDENTIFY = 8'h00;
    localparam byte_t OP_REG_READ = 8'h01;
    localparam byte_t OP_REG_WRITE = 8'h02;
    localparam byte_t OP_MEM_READ = 8'h03;
    localparam byte_t OP_MEM_WRITE = 8'h04;
    localparam byte_t REG_STATUS = 8'h00;
    localparam byte_t REG_ADDRESS = 8'h01;
    localparam byte_t REG_SCR = 8'h02;
    localparam byte_t FPGA_ID = 8'h64;

    logic clk;
    logic reset;
    logic frame_start;
    logic rx_valid;
    byte_t rx_data;
    byte_t tx_data;
    logic button;
    logic sd_det;
    logic mem_request;
    logic mem_write;
    mem_addr_t mem_address;
    word_t mem_wdata;
    logic mem_ack;
    word_t mem_rdata;

    word_t model [0:1023];
    word_t pattern [0:15];
    word_t readback [0:15];
    logic [31:0] rand_state;
    int ack_count;
    int error_count;
    int check_count;

    mcu_top dut0 (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .tx_data(tx_data),
        .button(button),
        .sd_det(sd_det),
        .mem_request(mem_request),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Initial memory word, distinct per index
    function automatic word_t fill_word(input int index);
        return 16'((index * 40503) ^ 32'h0000c3a5);
    endfunction

    // Memory model acking 1 to 4 cycles after the request
    initial begin
        int idx;
        int delay;
        mem_ack = 1'b0;
        mem_rdata = '0;
        ack_count = 0;
        for (idx = 0; idx < 1024; idx++) begin
            model[idx] = fill_word(idx);
        end
        forever begin
            @(negedge clk);
            if (mem_request) begin
                rand_state = xorshift32(rand_state);
                delay = int'(rand_state[1:0]) + 1;
                repeat (delay - 1) @(negedge clk);
                idx = int'(mem_address[10:1]);
                mem_ack = 1'b1;
                mem_rdata = model[idx];
                if (mem_write) begin
                    model[idx] = mem_wdata;
                end
                ack_count++;
                @(negedge clk);
                mem_ack = 1'b0;
            end
        end
    end

    task automatic check_equal(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual == expected) else begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic fill_pattern(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            rand_state = xorshift32(rand_state);
            pattern[i] = rand_state[15:0];
        end
    endtask

    task automatic start_frame();
        @(negedge clk);
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    // Response is sampled while the strobe is high
    task automatic send_byte(input byte_t value, output byte_t response);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_data = value;
        #1;
        response = tx_data;
        @(negedge clk);
        rx_valid = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic write_register(input byte_t index, input logic [31:0] value);
        byte_t resp;
        int i;
        start_frame();
        send_byte(OP_REG_WRITE, resp);
        send_byte(index, resp);
        for (i = 0; i < 4; i++) begin
            send_byte(value[8*i +: 8], resp);
        end
    endtask

    task automatic read_register(input byte_t index, output logic [31:0] value);
        byte_t resp;
        int i;
        value = '0;
        start_frame();
        send_byte(OP_REG_READ, resp);
        send_byte(index, resp);
        for (i = 0; i < 4; i++) begin
            send_byte(8'h00, resp);
            value[8*i +: 8] = resp;
        end
    endtask

    task automatic write_buffer(input byte_t pair, input int count);
        byte_t resp;
        int i;
        start_frame();
        send_byte(OP_MEM_WRITE, resp);
        send_byte(pair, resp);
        for (i = 0; i < count; i++) begin
            send_byte(pattern[i][15:8], resp);
            send_byte(pattern[i][7:0], resp);
        end
    endtask

    task automatic read_buffer(input byte_t pair, input int count);
        byte_t resp;
        byte_t high;
        int i;
        start_frame();
        send_byte(OP_MEM_READ, resp);
        send_byte(pair, resp);
        for (i = 0; i < count; i++) begin
            send_byte(8'h00, high);
            send_byte(8'h00, resp);
            readback[i] = {high, resp};
        end
    endtask

    task automatic wait_dma_idle(input string test);
        logic [31:0] scr;
        int polls;
        polls = 0;
        scr = 32'h8;
        while (scr[3] && polls < 100) begin
            read_register(REG_SCR, scr);
            polls++;
        end
        check_count++;
        assert (!scr[3]) else begin
            error_count++;
            $display("%s: DMA still busy after %0d status polls", test, polls);
        end
    endtask

    task automatic identify_frame();
        byte_t resp;
        start_frame();
        send_byte(OP_IDENTIFY, resp);
        send_byte(8'h00, resp);
        send_byte(8'h00, resp);
        check_equal("identify", 32'(FPGA_ID), 32'(resp));
    endtask

    task automatic register_access();
        logic [31:0] value;
        logic [31:0] got;
        rand_state = xorshift32(rand_state);
        value = rand_state;
        write_register(REG_ADDRESS, value);
        read_register(REG_ADDRESS, got);
        check_equal("reg_mem_address", value, got);

        // STATUS shows the active low inputs inverted
        @(negedge clk);
        button = 1'b0;
        sd_det = 1'b1;
        repeat (10) @(negedge clk);
        read_register(REG_STATUS, got);
        check_equal("reg_status_button", {30'd0, ~sd_det, ~button}, got);
        @(negedge clk);
        button = 1'b1;
        sd_det = 1'b0;
        repeat (10) @(negedge clk);
        read_register(REG_STATUS, got);
        check_equal("reg_status_sd_det", {30'd0, ~sd_det, ~button}, got);
    endtask

    task automatic buffer_access();
        int i;
        fill_pattern(8);
        write_buffer(8'h10, 8);
        read_buffer(8'h10, 8);
        for (i = 0; i < 8; i++) begin
            check_equal("buffer_access", 32'(pattern[i]), 32'(readback[i]));
        end
    endtask

    task automatic dma_to_memory();
        mem_addr_t base;
        int i;
        base = 32'h0000_0100;
        fill_pattern(8);
        write_buffer(8'h00, 8);
        write_register(REG_ADDRESS, base);
        // Start, buffer to memory, 8 words
        write_register(REG_SCR, 32'h5 | (32'd8 << 5));
        wait_dma_idle("dma_to_memory");
        for (i = 0; i < 8; i++) begin
            check_equal("dma_to_memory", 32'(pattern[i]), 32'(model[int'(base[10:1]) + i]));
        end
    endtask

    task automatic dma_from_memory();
        mem_addr_t base;
        int i;
        base = 32'h0000_0400;
        write_register(REG_ADDRESS, base);
        write_register(REG_SCR, 32'h1 | (32'd8 << 5));
        wait_dma_idle("dma_from_memory");
        read_buffer(8'h00, 8);
        for (i = 0; i < 8; i++) begin
            check_equal("dma_from_memory", 32'(fill_word(int'(base[10:1]) + i)),
                        32'(readback[i]));
        end
    endtask

    task automatic dma_stop();
        mem_addr_t base;
        int moved;
        base = 32'h0000_0600;
        write_register(REG_ADDRESS, base);
        ack_count = 0;
        write_register(REG_SCR, 32'h5 | (32'd256 << 5));
        write_register(REG_SCR, 32'h6 | (32'd256 << 5));
        wait_dma_idle("dma_stop");
        moved = ack_count;
        check_count++;
        assert (moved > 0 && moved < 256) else begin
            error_count++;
            $display("mismatch dma_stop: expected 1 to 255 words moved, actual %0d", moved);
        end
        if (moved < 256) begin
            check_equal("dma_stop_untouched", 32'(fill_word(768 + moved)),
                        32'(model[768 + moved]));
        end
    endtask

    initial begin
        reset = 1'b1;
        frame_start = 1'b0;
        rx_valid = 1'b0;
        rx_data = '0;
        button = 1'b1;
        sd_det = 1'b1;
        rand_state = 32'h939a;
        error_count = 0;
        check_count = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        identify_frame();
        register_access();
        buffer_access();
        dma_to_memory();
        dma_from_memory();
        dma_stop();

        $display("checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* src/mcu_buffer.sv */
`timescale 1ns/100ps
`include "mcu_macros.svh"

module mcu_buffer
    import mcu_mem_pkg::*;
(
    input  logic       clk,
    buf_if.slave       host,
    input  buf_index_t dma_index,
    input  logic       dma_we,
    input  word_t      dma_wdata,
    output word_t      dma_rdata
);

    word_t mem [0:`MCU_BUF_WORDS-1];

    // Host and DMA never write in the same phase
    always_ff @(posedge clk) begin
        if (dma_we) begin
            mem[dma_index] <= dma_wdata;
        end else if (host.write) begin
            mem[host.index] <= host.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (host.read) begin
            host.rdata <= mem[host.index];
        end
    end

    // DMA needs the word in the same cycle it raises its request
    assign dma_rdata = mem[dma_index];

endmodule

/* src/mcu_ifaces.sv */
`timescale 1ns/100ps

// Register access from the protocol engine
interface reg_if import mcu_mem_pkg::*; ();
    logic read;
    logic write;
    reg_addr_t address;
    reg_data_t wdata;
    reg_data_t rdata;

    modport master (output read, write, address, wdata, input rdata);
    modport slave (input read, write, address, wdata, output rdata);
endinterface

// Host side port of the transfer buffer
interface buf_if import mcu_mem_pkg::*; ();
    logic read;
    logic write;
    buf_index_t index;
    word_t wdata;
    word_t rdata;

    modport master (output read, write, index, wdata, input rdata);
    modport slave (input read, write, index, wdata, output rdata);
endinterface

// DMA control from the register block
interface dma_ctrl_if import mcu_mem_pkg::*; ();
    logic start;
    logic stop;
    logic direction;
    xfer_len_t length;
    mem_addr_t address;
    logic busy;

    modport master (output start, stop, direction, length, address, input busy);
    modport slave (input start, stop, direction, length, address, output busy);
endinterface

/* src/mcu_mem_pkg.sv */
package mcu_mem_pkg;

    // Buffer and external memory word
    typedef logic [15:0] word_t;

    // Word index into the transfer buffer
    typedef logic [8:0] buf_index_t;

    // Register number, or word pair for buffer access
    typedef logic [7:0] reg_addr_t;

    typedef logic [31:0] reg_data_t;

    // External byte address
    typedef logic [31:0] mem_addr_t;

    // Number of words to move, minus one
    typedef logic [8:0] xfer_len_t;

endpackage

/* src/mcu_proto_pkg.sv */
package mcu_proto_pkg;

    // One byte as shifted in or out by the MCU link
    typedef logic [7:0] byte_t;

    typedef enum logic [7:0] {
        CMD_IDENTIFY = 8'd0,
        CMD_REG_READ = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    // Position inside a frame
    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    // Byte lane within a 32-bit register
    typedef logic [1:0] byte_pos_t;

endpackage

/* src/mcu_protocol.sv */
`timescale 1ns/100ps
`include "mcu_macros.svh"

module mcu_protocol
    import mcu_proto_pkg::*;
    import mcu_mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  frame_start,
    input  logic  rx_valid,
    input  byte_t rx_data,
    output byte_t tx_data,
    reg_if.master regs,
    buf_if.master buffer
);

    phase_e phase;
    cmd_e cmd;
    byte_pos_t counter;
    reg_addr_t address;
    logic word_select;
    reg_data_t reg_wdata;
    word_t word_wdata;

    assign regs.address = address;
    assign regs.wdata = reg_wdata;
    assign buffer.index = {address, word_select};
    assign buffer.wdata = word_wdata;

    always_ff @(posedge clk) begin
        regs.read <= 1'b0;
        regs.write <= 1'b0;
        buffer.read <= 1'b0;
        buffer.write <= 1'b0;

        if (reset) begin
            phase <= PHASE_NOP;
            cmd <= CMD_IDENTIFY;
            counter <= '0;
            word_select <= 1'b0;
        end else begin
            if (frame_start) begin
                counter <= '0;
                phase <= PHASE_CMD;
            end

            // Step to the next register, or word pair once both halves were used
            if (regs.read || regs.write || (word_select && (buffer.read || buffer.write))) begin
                address <= address + 1'b1;
            end

            if (rx_valid) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd <= cmd_e'(rx_data);
                        if (rx_data > CMD_MEM_WRITE) begin
                            phase <= PHASE_NOP;
                        end else begin
                            phase <= PHASE_ADDRESS;
                        end
                    end

                    PHASE_ADDRESS: begin
                        address <= rx_data;
                        counter <= '0;
                        word_select <= 1'b0;
                        phase <= PHASE_DATA;
                        if (cmd == CMD_REG_READ) begin
                            regs.read <= 1'b1;
                        end
                        if (cmd == CMD_MEM_READ) begin
                            buffer.read <= 1'b1;
                        end
                    end

                    PHASE_DATA: begin
                        counter <= counter + 1'b1;
                        case (cmd)
                            CMD_REG_READ: begin
                                if (counter == 2'd3) begin
                                    regs.read <= 1'b1;
                                end
                            end

                            CMD_REG_WRITE: begin
                                case (counter)
                                    2'd0: reg_wdata[7:0] <= rx_data;
                                    2'd1: reg_wdata[15:8] <= rx_data;
                                    2'd2: reg_wdata[23:16] <= rx_data;
                                    2'd3: reg_wdata[31:24] <= rx_data;
                                endcase
                                if (counter == 2'd3) begin
                                    regs.write <= 1'b1;
                                end
                            end

                            CMD_MEM_READ: begin
                                // Prefetch the next word once its predecessor is sent
                                if (counter[0]) begin
                                    buffer.read <= 1'b1;
                                    word_select <= ~word_select;
                                end
                            end

                            CMD_MEM_WRITE: begin
                                if (!counter[0]) begin
                                    word_wdata[15:8] <= rx_data;
                                end else begin
                                    word_wdata[7:0] <= rx_data;
                                    buffer.write <= 1'b1;
                                    word_select <= counter[1];
                                end
                            end

                            default: begin
                            end
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        tx_data = 8'h00;
        if (phase == PHASE_DATA) begin
            case (cmd)
                CMD_IDENTIFY: tx_data = `MCU_FPGA_ID;
                CMD_REG_READ: begin
                    case (counter)
                        2'd0: tx_data = regs.rdata[7:0];
                        2'd1: tx_data = regs.rdata[15:8];
                        2'd2: tx_data = regs.rdata[23:16];
                        2'd3: tx_data = regs.rdata[31:24];
                    endcase
                end
                // High byte goes out first
                CMD_MEM_READ: tx_data = counter[0] ? buffer.rdata[7:0] : buffer.rdata[15:8];
                default: tx_data = 8'h00;
            endcase
        end
    end

endmodule

/* src/mcu_regs.sv */
`timescale 1ns/100ps
`include "mcu_macros.svh"

module mcu_regs
    import mcu_mem_pkg::*;
(
    input logic clk,
    input logic reset,
    reg_if.slave regs,
    dma_ctrl_if.master dma,
    input logic button,
    input logic sd_det
);

    logic [2:0] button_ff;
    logic [2:0] sd_det_ff;
    mem_addr_t mem_address;

    assign dma.address = mem_address;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[1:0], button};
        sd_det_ff <= {sd_det_ff[1:0], sd_det};
    end

    always_ff @(posedge clk) begin
        if (regs.read) begin
            case (regs.address)
                // Active low inputs read back as set when pressed
                `MCU_REG_STATUS: regs.rdata <= {30'd0, ~sd_det_ff[2], ~button_ff[2]};
                `MCU_REG_MEM_ADDRESS: regs.rdata <= mem_address;
                `MCU_REG_MEM_SCR: regs.rdata <= {28'd0, dma.busy, 3'b000};
                default: regs.rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dma.start <= 1'b0;
        dma.stop <= 1'b0;

        if (reset) begin
            dma.direction <= 1'b0;
        end else if (regs.write) begin
            case (regs.address)
                `MCU_REG_MEM_ADDRESS: begin
                    mem_address <= regs.wdata;
                end

                `MCU_REG_MEM_SCR: begin
                    dma.start <= regs.wdata[0];
                    dma.stop <= regs.wdata[1];
                    dma.direction <= regs.wdata[2];
                    // Word count kept as count minus one
                    dma.length <= xfer_len_t'(regs.wdata[14:5] - 10'd1);
                end

                default: begin
                end
            endcase
        end
    end

endmodule

/* src/mcu_top.sv */
`timescale 1ns/100ps

module mcu_top
    import mcu_proto_pkg::*;
    import mcu_mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      frame_start,
    input  logic      rx_valid,
    input  byte_t     rx_data,
    output byte_t     tx_data,
    input  logic      button,
    input  logic      sd_det,
    output logic      mem_request,
    output logic      mem_write,
    output mem_addr_t mem_address,
    output word_t     mem_wdata,
    input  logic      mem_ack,
    input  word_t     mem_rdata
);

    reg_if regs_bus ();
    buf_if buf_bus ();
    dma_ctrl_if dma_bus ();

    // DMA side of the buffer
    buf_index_t dma_index;
    logic dma_we;
    word_t dma_wdata;
    word_t dma_rdata;

    mcu_protocol protocol_inst (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .tx_data(tx_data),
        .regs(regs_bus.master),
        .buffer(buf_bus.master)
    );

    mcu_regs regs_inst (
        .clk(clk),
        .reset(reset),
        .regs(regs_bus.slave),
        .dma(dma_bus.master),
        .button(button),
        .sd_det(sd_det)
    );

    mcu_buffer buffer_inst (
        .clk(clk),
        .host(buf_bus.slave),
        .dma_index(dma_index),
        .dma_we(dma_we),
        .dma_wdata(dma_wdata),
        .dma_rdata(dma_rdata)
    );

    mem_dma dma_inst (
        .clk(clk),
        .reset(reset),
        .ctrl(dma_bus.slave),
        .buf_index(dma_index),
        .buf_we(dma_we),
        .buf_wdata(dma_wdata),
        .buf_rdata(dma_rdata),
        .mem_request(mem_request),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

endmodule

/* src/mem_dma.sv */
`timescale 1ns/100ps
`include "mcu_macros.svh"

module mem_dma
    import mcu_mem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    dma_ctrl_if.slave  ctrl,
    output buf_index_t buf_index,
    output logic       buf_we,
    output word_t      buf_wdata,
    input  word_t      buf_rdata,
    output logic       mem_request,
    output logic       mem_write,
    output mem_addr_t  mem_address,
    output word_t      mem_wdata,
    input  logic       mem_ack,
    input  word_t      mem_rdata
);

    typedef enum logic {
        IDLE,
        XFER
    } state_e;

    state_e state;
    buf_index_t count;
    xfer_len_t length;
    logic stop_pending;
    logic word_done;

    assign ctrl.busy = (state == XFER);
    assign word_done = (state == XFER) && mem_request && mem_ack;

    assign buf_index = count;
    assign buf_wdata = mem_rdata;
    assign buf_we = word_done && !mem_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            mem_request <= 1'b0;
            mem_write <= 1'b0;
            stop_pending <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (ctrl.start) begin
                        mem_write <= ctrl.direction;
                        mem_address <= ctrl.address;
                        length <= ctrl.length;
                        count <= '0;
                        stop_pending <= 1'b0;
                        state <= XFER;
                    end
                end

                XFER: begin
                    if (ctrl.stop) begin
                        stop_pending <= 1'b1;
                    end

                    if (!mem_request) begin
                        mem_request <= 1'b1;
                        mem_wdata <= buf_rdata;
                    end else if (mem_ack) begin
                        // Request stays low for a cycle between words
                        mem_request <= 1'b0;
                        mem_address <= mem_address + `MCU_MEM_STEP;
                        count <= count + 1'b1;
                        if ((count == length) || stop_pending || ctrl.stop) begin
                            stop_pending <= 1'b0;
                            state <= IDLE;
                        end
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule
